// File: hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // register index, shared by integer and fpu register files
    typedef logic [4:0] reg_idx_t;

    // where an instruction's result comes from
    typedef logic [2:0] result_src_t;

    // exec operand select, integer side
    typedef logic [2:0] fwd_int_t;

    // exec operand select, fpu side
    typedef logic [1:0] fwd_fpu_t;

    // one data word
    typedef logic [31:0] word_t;

    // result source codes
    localparam result_src_t res_alu     = 3'd0;  // alu result
    localparam result_src_t res_load    = 3'd1;  // data memory / input port
    localparam result_src_t res_pc4     = 3'd2;  // jal, jalr link
    localparam result_src_t res_rd1     = 3'd3;  // integer rd1 moved into fpu file
    localparam result_src_t res_imm     = 3'd4;  // lui
    localparam result_src_t res_fpu_rd1 = 3'd5;  // fpu rd1 moved into integer file
    localparam result_src_t res_fpu     = 3'd6;  // fpu arithmetic result

    // integer forward codes
    // m-stage codes mirror the result source of the producer
    localparam fwd_int_t fwd_int_m_alu     = 3'd0;
    localparam fwd_int_t fwd_int_w         = 3'd1;  // write back value
    localparam fwd_int_t fwd_int_m_pc4     = 3'd2;
    localparam fwd_int_t fwd_int_m_imm     = 3'd4;
    localparam fwd_int_t fwd_int_m_fpu_rd1 = 3'd5;
    localparam fwd_int_t fwd_int_m_fpu     = 3'd6;
    localparam fwd_int_t fwd_int_none      = 3'd7;  // register file value

    // fpu forward codes
    localparam fwd_fpu_t fwd_fpu_none  = 2'd0;  // fpu register file value
    localparam fwd_fpu_t fwd_fpu_w     = 2'd1;  // write back value
    localparam fwd_fpu_t fwd_fpu_m_res = 2'd2;  // fpu result in mem stage
    localparam fwd_fpu_t fwd_fpu_m_rd1 = 2'd3;  // integer rd1 in mem stage

endpackage

`default_nettype wire

// File: hdl/hazard_unit.sv
`default_nettype none

module hazard_unit (
    // fetch
    output logic stall_f,

    // decode
    output logic stall_d,
    output logic flush_d,
    input  wire pipe_pkg::reg_idx_t rs1_d,
    input  wire pipe_pkg::reg_idx_t rs2_d,
    input  wire logic s_fpu_d,

    // exec
    output logic stall_e,
    output logic flush_e,
    input  wire pipe_pkg::reg_idx_t rs1_e,
    input  wire pipe_pkg::reg_idx_t rs2_e,
    input  wire pipe_pkg::reg_idx_t rd_e,
    input  wire logic pc_src_e,            // branch taken
    input  wire pipe_pkg::result_src_t result_src_e,
    input  wire logic s_fpu_e,             // exec sources read the fpu file
    input  wire logic reg_write_e,
    input  wire logic fpu_reg_write_e,
    input  wire logic fpu_dispatch_e,      // fpu op issued from exec
    output pipe_pkg::fwd_int_t forward_rd1_e,
    output pipe_pkg::fwd_int_t forward_rd2_e,
    output pipe_pkg::fwd_fpu_t forward_fpu_rd1_e,
    output pipe_pkg::fwd_fpu_t forward_fpu_rd2_e,
    output logic cache_stall,

    // memory access
    output logic stall_m,
    input  wire pipe_pkg::reg_idx_t rd_m,
    input  wire logic reg_write_m,
    input  wire pipe_pkg::result_src_t result_src_m,
    input  wire logic mem_write_m,
    input  wire logic mem_read_m,
    input  wire logic fpu_reg_write_m,
    input  wire logic cache_data_valid,

    // write back
    output logic stall_w,
    input  wire pipe_pkg::reg_idx_t rd_w,
    input  wire logic reg_write_w,
    input  wire logic fpu_reg_write_w,

    // i/o module and fpu
    input  wire logic out_stall,
    input  wire logic in_stall,
    input  wire logic fpu_valid,

    output logic lw_stall
);

    logic fpu_wait;  // fpu op in exec, result not ready yet
    logic io_stall;

    // integer operand select, mem stage wins over write back
    function automatic pipe_pkg::fwd_int_t int_select(input pipe_pkg::reg_idx_t rs);
        pipe_pkg::fwd_int_t sel;
        sel = pipe_pkg::fwd_int_none;
        if ((rs == rd_m) && !s_fpu_e && reg_write_m && (rs != '0)) begin
            case (result_src_m)
                pipe_pkg::res_alu:     sel = pipe_pkg::fwd_int_m_alu;
                pipe_pkg::res_pc4:     sel = pipe_pkg::fwd_int_m_pc4;
                pipe_pkg::res_imm:     sel = pipe_pkg::fwd_int_m_imm;
                pipe_pkg::res_fpu_rd1: sel = pipe_pkg::fwd_int_m_fpu_rd1;
                pipe_pkg::res_fpu:     sel = pipe_pkg::fwd_int_m_fpu;
                default:               sel = pipe_pkg::fwd_int_m_alu;  // load/rd1 never a source
            endcase
        end else if ((rs == rd_w) && !s_fpu_e && reg_write_w && (rs != '0)) begin
            sel = pipe_pkg::fwd_int_w;
        end
        return sel;
    endfunction

    // fpu operand select, f0 is a real register so no zero check
    function automatic pipe_pkg::fwd_fpu_t fpu_select(input pipe_pkg::reg_idx_t rs);
        pipe_pkg::fwd_fpu_t sel;
        sel = pipe_pkg::fwd_fpu_none;
        if ((rs == rd_m) && s_fpu_e && fpu_reg_write_m) begin
            case (result_src_m)
                pipe_pkg::res_rd1: sel = pipe_pkg::fwd_fpu_m_rd1;  // fmv.w.x style move
                pipe_pkg::res_fpu: sel = pipe_pkg::fwd_fpu_m_res;
                default:           sel = pipe_pkg::fwd_fpu_none;   // flw etc, not forwardable
            endcase
        end else if ((rs == rd_w) && s_fpu_e && fpu_reg_write_w) begin
            sel = pipe_pkg::fwd_fpu_w;
        end
        return sel;
    endfunction

    always_comb begin
        forward_rd1_e     = int_select(rs1_e);
        forward_rd2_e     = int_select(rs2_e);
        forward_fpu_rd1_e = fpu_select(rs1_e);
        forward_fpu_rd2_e = fpu_select(rs2_e);
    end

    // load in exec feeding the decode instruction, file chosen by s_fpu_d
    assign lw_stall = (result_src_e == pipe_pkg::res_load)
                    && ((rs1_d == rd_e) || (rs2_d == rd_e))
                    && ((!s_fpu_d && reg_write_e) || (s_fpu_d && fpu_reg_write_e));

    assign cache_stall = (mem_read_m || mem_write_m) && !cache_data_valid;
    assign fpu_wait    = fpu_dispatch_e && !fpu_valid;
    assign io_stall    = in_stall || out_stall;

    // front end freezes on anything
    assign stall_f = lw_stall || cache_stall || io_stall || fpu_wait;
    assign stall_d = lw_stall || cache_stall || io_stall || fpu_wait;

    // exec freezes on all but load-use, which bubbles it instead
    assign stall_e = cache_stall || io_stall || fpu_wait;

    // back end only waits on the cache
    assign stall_m = cache_stall;
    assign stall_w = cache_stall;

    assign flush_d = pc_src_e;

    // exec must survive a cache stall so lw_stall stays up until memory is back;
    // an in op or a waiting fpu op has to stay in exec as well
    assign flush_e = (lw_stall || pc_src_e) && !cache_stall && !in_stall && !fpu_wait;

endmodule

`default_nettype wire

// File: hdl/tag_pipeline.sv
`default_nettype none

module tag_pipeline (
    input  wire logic clk,
    input  wire logic rst_n,

    // strobes from the hazard unit
    input  wire logic stall_e,
    input  wire logic flush_e,
    input  wire logic stall_m,
    input  wire logic stall_w,

    // decode tags
    input  wire pipe_pkg::reg_idx_t rs1_d,
    input  wire pipe_pkg::reg_idx_t rs2_d,
    input  wire pipe_pkg::reg_idx_t rd_d,
    input  wire logic s_fpu_d,
    input  wire logic reg_write_d,
    input  wire logic fpu_reg_write_d,
    input  wire pipe_pkg::result_src_t result_src_d,
    input  wire logic mem_read_d,
    input  wire logic mem_write_d,
    input  wire logic fpu_dispatch_d,

    // exec tags
    output pipe_pkg::reg_idx_t rs1_e,
    output pipe_pkg::reg_idx_t rs2_e,
    output pipe_pkg::reg_idx_t rd_e,
    output logic s_fpu_e,
    output logic reg_write_e,
    output logic fpu_reg_write_e,
    output pipe_pkg::result_src_t result_src_e,
    output logic mem_read_e,
    output logic mem_write_e,
    output logic fpu_dispatch_e,

    // memory access tags
    output pipe_pkg::reg_idx_t rd_m,
    output logic reg_write_m,
    output logic fpu_reg_write_m,
    output pipe_pkg::result_src_t result_src_m,
    output logic mem_read_m,
    output logic mem_write_m,

    // write back tags
    output pipe_pkg::reg_idx_t rd_w,
    output logic reg_write_w,
    output logic fpu_reg_write_w
);

    // exec bank, flush beats stall so a taken branch under out_stall still kills it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs1_e           <= '0;
            rs2_e           <= '0;
            rd_e            <= '0;
            s_fpu_e         <= 1'b0;
            reg_write_e     <= 1'b0;
            fpu_reg_write_e <= 1'b0;
            result_src_e    <= pipe_pkg::res_alu;
            mem_read_e      <= 1'b0;
            mem_write_e     <= 1'b0;
            fpu_dispatch_e  <= 1'b0;
        end else if (flush_e) begin      // bubble, indices cleared too
            rs1_e           <= '0;
            rs2_e           <= '0;
            rd_e            <= '0;
            s_fpu_e         <= 1'b0;
            reg_write_e     <= 1'b0;
            fpu_reg_write_e <= 1'b0;
            result_src_e    <= pipe_pkg::res_alu;
            mem_read_e      <= 1'b0;
            mem_write_e     <= 1'b0;
            fpu_dispatch_e  <= 1'b0;
        end else if (!stall_e) begin     // advance from decode
            rs1_e           <= rs1_d;
            rs2_e           <= rs2_d;
            rd_e            <= rd_d;
            s_fpu_e         <= s_fpu_d;
            reg_write_e     <= reg_write_d;
            fpu_reg_write_e <= fpu_reg_write_d;
            result_src_e    <= result_src_d;
            mem_read_e      <= mem_read_d;
            mem_write_e     <= mem_write_d;
            fpu_dispatch_e  <= fpu_dispatch_d;
        end
        // else hold, keeps a stalled load visible to lw_stall
    end

    // memory bank
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_m            <= '0;
            reg_write_m     <= 1'b0;
            fpu_reg_write_m <= 1'b0;
            result_src_m    <= pipe_pkg::res_alu;
            mem_read_m      <= 1'b0;
            mem_write_m     <= 1'b0;
        end else if (stall_m) begin
            // cache busy, hold
        end else if (stall_e) begin      // exec frozen, feed a bubble
            rd_m            <= '0;
            reg_write_m     <= 1'b0;
            fpu_reg_write_m <= 1'b0;
            result_src_m    <= pipe_pkg::res_alu;
            mem_read_m      <= 1'b0;
            mem_write_m     <= 1'b0;
        end else begin
            rd_m            <= rd_e;
            reg_write_m     <= reg_write_e;
            fpu_reg_write_m <= fpu_reg_write_e;
            result_src_m    <= result_src_e;
            mem_read_m      <= mem_read_e;
            mem_write_m     <= mem_write_e;
        end
    end

    // write back bank, only what the forward compare needs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_w            <= '0;
            reg_write_w     <= 1'b0;
            fpu_reg_write_w <= 1'b0;
        end else if (!stall_w) begin
            rd_w            <= rd_m;
            reg_write_w     <= reg_write_m;
            fpu_reg_write_w <= fpu_reg_write_m;
        end
    end

endmodule

`default_nettype wire

// File: hdl/operand_forward.sv
`default_nettype none

module operand_forward (
    // selects from the hazard unit
    input  wire pipe_pkg::fwd_int_t forward_rd1_e,
    input  wire pipe_pkg::fwd_int_t forward_rd2_e,
    input  wire pipe_pkg::fwd_fpu_t forward_fpu_rd1_e,
    input  wire pipe_pkg::fwd_fpu_t forward_fpu_rd2_e,

    // register file reads, exec stage
    input  wire pipe_pkg::word_t rf_rd1_e,
    input  wire pipe_pkg::word_t rf_rd2_e,
    input  wire pipe_pkg::word_t frf_rd1_e,
    input  wire pipe_pkg::word_t frf_rd2_e,

    // later-stage values
    input  wire pipe_pkg::word_t alu_result_m,
    input  wire pipe_pkg::word_t pc_plus4_m,
    input  wire pipe_pkg::word_t imm_ext_m,
    input  wire pipe_pkg::word_t fpu_rd1_m,
    input  wire pipe_pkg::word_t fpu_result_m,
    input  wire pipe_pkg::word_t rd1_m,
    input  wire pipe_pkg::word_t result_w,

    // exec operands
    output pipe_pkg::word_t src_a_e,
    output pipe_pkg::word_t src_b_e,
    output pipe_pkg::word_t fsrc_a_e,
    output pipe_pkg::word_t fsrc_b_e
);

    // integer mux, m-stage codes follow the producer's result source
    function automatic pipe_pkg::word_t int_mux(input pipe_pkg::fwd_int_t sel,
                                                 input pipe_pkg::word_t rf);
        pipe_pkg::word_t val;
        case (sel)
            pipe_pkg::fwd_int_m_alu:     val = alu_result_m;
            pipe_pkg::fwd_int_m_pc4:     val = pc_plus4_m;
            pipe_pkg::fwd_int_m_imm:     val = imm_ext_m;
            pipe_pkg::fwd_int_m_fpu_rd1: val = fpu_rd1_m;  // fmv.x.w in mem
            pipe_pkg::fwd_int_m_fpu:     val = fpu_result_m;
            pipe_pkg::fwd_int_w:         val = result_w;
            default:                     val = rf;         // none, code 3 unused
        endcase
        return val;
    endfunction

    // fpu mux, four codes, all decoded
    function automatic pipe_pkg::word_t fpu_mux(input pipe_pkg::fwd_fpu_t sel,
                                                input pipe_pkg::word_t frf);
        pipe_pkg::word_t val;
        case (sel)
            pipe_pkg::fwd_fpu_m_rd1: val = rd1_m;         // integer value headed for fpu file
            pipe_pkg::fwd_fpu_m_res: val = fpu_result_m;
            pipe_pkg::fwd_fpu_w:     val = result_w;
            default:                 val = frf;
        endcase
        return val;
    endfunction

    always_comb begin
        src_a_e  = int_mux(forward_rd1_e, rf_rd1_e);
        src_b_e  = int_mux(forward_rd2_e, rf_rd2_e);
        fsrc_a_e = fpu_mux(forward_fpu_rd1_e, frf_rd1_e);
        fsrc_b_e = fpu_mux(forward_fpu_rd2_e, frf_rd2_e);
    end

endmodule

`default_nettype wire

// File: hdl/pipe_ctrl_top.sv
`default_nettype none

module pipe_ctrl_top (
    input  wire logic clk,
    input  wire logic rst_n,

    // decode tags
    input  wire pipe_pkg::reg_idx_t rs1_d,
    input  wire pipe_pkg::reg_idx_t rs2_d,
    input  wire pipe_pkg::reg_idx_t rd_d,
    input  wire logic s_fpu_d,
    input  wire logic reg_write_d,
    input  wire logic fpu_reg_write_d,
    input  wire pipe_pkg::result_src_t result_src_d,
    input  wire logic mem_read_d,
    input  wire logic mem_write_d,
    input  wire logic fpu_dispatch_d,

    // status from outside the slice
    input  wire logic pc_src_e,
    input  wire logic cache_data_valid,
    input  wire logic in_stall,
    input  wire logic out_stall,
    input  wire logic fpu_valid,

    // operand sources
    input  wire pipe_pkg::word_t rf_rd1_e,
    input  wire pipe_pkg::word_t rf_rd2_e,
    input  wire pipe_pkg::word_t frf_rd1_e,
    input  wire pipe_pkg::word_t frf_rd2_e,
    input  wire pipe_pkg::word_t alu_result_m,
    input  wire pipe_pkg::word_t pc_plus4_m,
    input  wire pipe_pkg::word_t imm_ext_m,
    input  wire pipe_pkg::word_t fpu_rd1_m,
    input  wire pipe_pkg::word_t fpu_result_m,
    input  wire pipe_pkg::word_t rd1_m,
    input  wire pipe_pkg::word_t result_w,

    // hazard strobes
    output logic stall_f,
    output logic stall_d,
    output logic flush_d,
    output logic stall_e,
    output logic flush_e,
    output logic stall_m,
    output logic stall_w,
    output logic cache_stall,
    output logic lw_stall,
    output pipe_pkg::fwd_int_t forward_rd1_e,
    output pipe_pkg::fwd_int_t forward_rd2_e,
    output pipe_pkg::fwd_fpu_t forward_fpu_rd1_e,
    output pipe_pkg::fwd_fpu_t forward_fpu_rd2_e,

    // forwarded exec operands
    output pipe_pkg::word_t src_a_e,
    output pipe_pkg::word_t src_b_e,
    output pipe_pkg::word_t fsrc_a_e,
    output pipe_pkg::word_t fsrc_b_e
);

    pipe_pkg::reg_idx_t    rs1_e, rs2_e, rd_e, rd_m, rd_w;
    pipe_pkg::result_src_t result_src_e, result_src_m;
    logic s_fpu_e, reg_write_e, fpu_reg_write_e, fpu_dispatch_e;
    logic reg_write_m, fpu_reg_write_m, mem_read_m, mem_write_m;
    logic reg_write_w, fpu_reg_write_w;

    tag_pipeline tag_pipeline_inst (
        .clk, .rst_n,
        .stall_e, .flush_e, .stall_m, .stall_w,
        .rs1_d, .rs2_d, .rd_d, .s_fpu_d, .reg_write_d, .fpu_reg_write_d,
        .result_src_d, .mem_read_d, .mem_write_d, .fpu_dispatch_d,
        .rs1_e, .rs2_e, .rd_e, .s_fpu_e, .reg_write_e, .fpu_reg_write_e,
        .result_src_e,
        .mem_read_e  (),  // only feeds the m bank
        .mem_write_e (),
        .fpu_dispatch_e,
        .rd_m, .reg_write_m, .fpu_reg_write_m, .result_src_m, .mem_read_m, .mem_write_m,
        .rd_w, .reg_write_w, .fpu_reg_write_w
    );

    hazard_unit hazard_unit_inst (
        .stall_f, .stall_d, .flush_d,
        .rs1_d, .rs2_d, .s_fpu_d,
        .stall_e, .flush_e,
        .rs1_e, .rs2_e, .rd_e, .pc_src_e, .result_src_e, .s_fpu_e,
        .reg_write_e, .fpu_reg_write_e, .fpu_dispatch_e,
        .forward_rd1_e, .forward_rd2_e, .forward_fpu_rd1_e, .forward_fpu_rd2_e,
        .cache_stall,
        .stall_m, .rd_m, .reg_write_m, .result_src_m, .mem_write_m, .mem_read_m,
        .fpu_reg_write_m, .cache_data_valid,
        .stall_w, .rd_w, .reg_write_w, .fpu_reg_write_w,
        .out_stall, .in_stall, .fpu_valid,
        .lw_stall
    );

    operand_forward operand_forward_inst (
        .forward_rd1_e, .forward_rd2_e, .forward_fpu_rd1_e, .forward_fpu_rd2_e,
        .rf_rd1_e, .rf_rd2_e, .frf_rd1_e, .frf_rd2_e,
        .alu_result_m, .pc_plus4_m, .imm_ext_m, .fpu_rd1_m, .fpu_result_m, .rd1_m,
        .result_w,
        .src_a_e, .src_b_e, .fsrc_a_e, .fsrc_b_e
    );

endmodule

`default_nettype wire

// File: test/pipe_ctrl_tb.sv
`default_nettype none

module pipe_ctrl_tb;

    localparam int reset_cycles = 16;
    localparam int test_cycles  = 400;
    localparam int num_tests    = 6;
    localparam int total_cycles = num_tests * test_cycles + reset_cycles + 8;
    localparam int timeout      = total_cycles * 8 * 2;  // twice the expected run

    logic clk, rst_n;

    // decode tags and status into the dut
    pipe_pkg::reg_idx_t rs1_d, rs2_d, rd_d;
    pipe_pkg::result_src_t result_src_d;
    logic s_fpu_d, reg_write_d, fpu_reg_write_d, mem_read_d, mem_write_d, fpu_dispatch_d;
    logic pc_src_e, cache_data_valid, in_stall, out_stall, fpu_valid;
    pipe_pkg::word_t rf_rd1_e, rf_rd2_e, frf_rd1_e, frf_rd2_e;
    pipe_pkg::word_t alu_result_m, pc_plus4_m, imm_ext_m, fpu_rd1_m, fpu_result_m, rd1_m;
    pipe_pkg::word_t result_w;

    // dut outputs
    logic stall_f, stall_d, flush_d, stall_e, flush_e, stall_m, stall_w;
    logic cache_stall, lw_stall;
    pipe_pkg::fwd_int_t forward_rd1_e, forward_rd2_e;
    pipe_pkg::fwd_fpu_t forward_fpu_rd1_e, forward_fpu_rd2_e;
    pipe_pkg::word_t src_a_e, src_b_e, fsrc_a_e, fsrc_b_e;

    // model copies of the e, m and w tags
    pipe_pkg::reg_idx_t mod_rs1_e, mod_rs2_e, mod_rd_e, mod_rd_m, mod_rd_w;
    pipe_pkg::result_src_t mod_src_e, mod_src_m;
    logic mod_fpu_e, mod_rw_e, mod_frw_e, mod_mr_e, mod_mw_e, mod_disp_e;
    logic mod_rw_m, mod_frw_m, mod_mr_m, mod_mw_m, mod_rw_w, mod_frw_w;

    // expected values for the current cycle
    logic ex_lw, ex_cache, ex_fwait, ex_stall_fd, ex_stall_e, ex_stall_mw, ex_flush_e;
    pipe_pkg::fwd_int_t ex_fwd1, ex_fwd2, prev_fwd1, prev_fwd2;
    pipe_pkg::fwd_fpu_t ex_ffwd1, ex_ffwd2, prev_ffwd1, prev_ffwd2;
    logic held;  // last cycle was a cache stall

    logic [31:0] seed;
    int p_load, p_fpu, p_mem, p_miss, p_branch, p_io, p_disp, p_wait;  // percent biases
    int checks, errors;

    pipe_ctrl_top pipe_ctrl_top_inst (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rnd();
        seed = xorshift(seed);
        return seed;
    endfunction

    function automatic logic chance(input int pct);
        return (rnd() % 100) < pct;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_fwd_int(input string name, input pipe_pkg::fwd_int_t got,
                                 input pipe_pkg::fwd_int_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_fwd_fpu(input string name, input pipe_pkg::fwd_fpu_t got,
                                 input pipe_pkg::fwd_fpu_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input pipe_pkg::word_t got,
                              input pipe_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // m stage wins over w stage
    // load, rd1 and code 7 fall back to select 0
    function automatic pipe_pkg::fwd_int_t model_int_fwd(input pipe_pkg::reg_idx_t rs);
        pipe_pkg::fwd_int_t sel;
        sel = pipe_pkg::fwd_int_none;
        if (rs != '0 && !mod_fpu_e) begin  // x0 never forwards
            if (mod_rw_m && rs == mod_rd_m) begin
                if (mod_src_m == pipe_pkg::res_load || mod_src_m == pipe_pkg::res_rd1
                    || mod_src_m > pipe_pkg::res_fpu)
                    sel = pipe_pkg::fwd_int_m_alu;
                else
                    sel = mod_src_m;  // code equals result source
            end else if (mod_rw_w && rs == mod_rd_w) begin
                sel = pipe_pkg::fwd_int_w;
            end
        end
        return sel;
    endfunction

    function automatic pipe_pkg::fwd_fpu_t model_fpu_fwd(input pipe_pkg::reg_idx_t rs);
        pipe_pkg::fwd_fpu_t sel;
        sel = pipe_pkg::fwd_fpu_none;
        if (mod_fpu_e && mod_frw_m && rs == mod_rd_m) begin
            if (mod_src_m == pipe_pkg::res_rd1)
                sel = pipe_pkg::fwd_fpu_m_rd1;
            else if (mod_src_m == pipe_pkg::res_fpu)
                sel = pipe_pkg::fwd_fpu_m_res;
        end else if (mod_fpu_e && mod_frw_w && rs == mod_rd_w) begin
            sel = pipe_pkg::fwd_fpu_w;
        end
        return sel;
    endfunction

    // value table indexed by select code
    function automatic pipe_pkg::word_t model_int_word(input pipe_pkg::fwd_int_t sel,
                                                       input pipe_pkg::word_t rf);
        pipe_pkg::word_t pick [0:7];
        pick = '{alu_result_m, result_w, pc_plus4_m, rf, imm_ext_m,
                 fpu_rd1_m, fpu_result_m, rf};
        return pick[sel];
    endfunction

    function automatic pipe_pkg::word_t model_fpu_word(input pipe_pkg::fwd_fpu_t sel,
                                                       input pipe_pkg::word_t frf);
        pipe_pkg::word_t pick [0:3];
        pick = '{frf, result_w, fpu_result_m, rd1_m};
        return pick[sel];
    endfunction

    task automatic drive_inputs();
        rs1_d            = pipe_pkg::reg_idx_t'(rnd() % 4);  // tiny index range gives lots of hazards
        rs2_d            = pipe_pkg::reg_idx_t'(rnd() % 4);
        rd_d             = pipe_pkg::reg_idx_t'(rnd() % 4);
        s_fpu_d          = chance(p_fpu);
        reg_write_d      = chance(60);
        fpu_reg_write_d  = chance(40);
        result_src_d     = chance(p_load) ? pipe_pkg::res_load
                                          : pipe_pkg::result_src_t'(rnd() % 8);
        mem_read_d       = chance(p_mem);
        mem_write_d      = chance(p_mem / 2);
        fpu_dispatch_d   = chance(p_disp);
        pc_src_e         = chance(p_branch);
        cache_data_valid = !chance(p_miss);
        in_stall         = chance(p_io);
        out_stall        = chance(p_io);
        fpu_valid        = !chance(p_wait);
        rf_rd1_e         = rnd();
        rf_rd2_e         = rnd();
        frf_rd1_e        = rnd();
        frf_rd2_e        = rnd();
        alu_result_m     = rnd();
        pc_plus4_m       = rnd();
        imm_ext_m        = rnd();
        fpu_rd1_m        = rnd();
        fpu_result_m     = rnd();
        rd1_m            = rnd();
        result_w         = rnd();
    endtask

    task automatic compute_expected();
        ex_lw = (mod_src_e == pipe_pkg::res_load)
              && (rs1_d == mod_rd_e || rs2_d == mod_rd_e)
              && (s_fpu_d ? mod_frw_e : mod_rw_e);
        ex_cache    = (mod_mr_m || mod_mw_m) && !cache_data_valid;
        ex_fwait    = mod_disp_e && !fpu_valid;
        ex_stall_e  = ex_cache || in_stall || out_stall || ex_fwait;
        ex_stall_fd = ex_stall_e || ex_lw;
        ex_stall_mw = ex_cache;
        ex_flush_e  = (ex_lw || pc_src_e) && !(ex_cache || in_stall || ex_fwait);
        ex_fwd1  = model_int_fwd(mod_rs1_e);
        ex_fwd2  = model_int_fwd(mod_rs2_e);
        ex_ffwd1 = model_fpu_fwd(mod_rs1_e);
        ex_ffwd2 = model_fpu_fwd(mod_rs2_e);
    endtask

    task automatic check_all();
        check_bit("lw_stall", lw_stall, ex_lw);
        check_bit("cache_stall", cache_stall, ex_cache);
        check_bit("stall_f", stall_f, ex_stall_fd);
        check_bit("stall_d", stall_d, ex_stall_fd);
        check_bit("flush_d", flush_d, pc_src_e);
        check_bit("stall_e", stall_e, ex_stall_e);
        check_bit("flush_e", flush_e, ex_flush_e);
        check_bit("stall_m", stall_m, ex_stall_mw);
        check_bit("stall_w", stall_w, ex_stall_mw);
        check_fwd_int("forward_rd1_e", forward_rd1_e, ex_fwd1);
        check_fwd_int("forward_rd2_e", forward_rd2_e, ex_fwd2);
        check_fwd_fpu("forward_fpu_rd1_e", forward_fpu_rd1_e, ex_ffwd1);
        check_fwd_fpu("forward_fpu_rd2_e", forward_fpu_rd2_e, ex_ffwd2);
        check_word("src_a_e", src_a_e, model_int_word(ex_fwd1, rf_rd1_e));
        check_word("src_b_e", src_b_e, model_int_word(ex_fwd2, rf_rd2_e));
        check_word("fsrc_a_e", fsrc_a_e, model_fpu_word(ex_ffwd1, frf_rd1_e));
        check_word("fsrc_b_e", fsrc_b_e, model_fpu_word(ex_ffwd2, frf_rd2_e));
        if (held) begin  // whole pipe froze so selects must not move
            check_fwd_int("forward_rd1_e", forward_rd1_e, prev_fwd1);
            check_fwd_int("forward_rd2_e", forward_rd2_e, prev_fwd2);
            check_fwd_fpu("forward_fpu_rd1_e", forward_fpu_rd1_e, prev_ffwd1);
            check_fwd_fpu("forward_fpu_rd2_e", forward_fpu_rd2_e, prev_ffwd2);
        end
        held = ex_cache;
        prev_fwd1 = ex_fwd1;
        prev_fwd2 = ex_fwd2;
        prev_ffwd1 = ex_ffwd1;
        prev_ffwd2 = ex_ffwd2;
    endtask

    task automatic clear_exec();
        mod_rs1_e  = '0;
        mod_rs2_e  = '0;
        mod_rd_e   = '0;
        mod_fpu_e  = 1'b0;
        mod_rw_e   = 1'b0;
        mod_frw_e  = 1'b0;
        mod_src_e  = pipe_pkg::res_alu;
        mod_mr_e   = 1'b0;
        mod_mw_e   = 1'b0;
        mod_disp_e = 1'b0;
    endtask

    task automatic clear_mem();
        mod_rd_m  = '0;
        mod_rw_m  = 1'b0;
        mod_frw_m = 1'b0;
        mod_src_m = pipe_pkg::res_alu;
        mod_mr_m  = 1'b0;
        mod_mw_m  = 1'b0;
    endtask

    // back to front so each stage sees the old value of the one before
    task automatic update_model();
        if (!ex_stall_mw) begin
            mod_rd_w  = mod_rd_m;
            mod_rw_w  = mod_rw_m;
            mod_frw_w = mod_frw_m;
            if (ex_stall_e) begin
                clear_mem();  // bubble behind a frozen exec
            end else begin
                mod_rd_m  = mod_rd_e;
                mod_rw_m  = mod_rw_e;
                mod_frw_m = mod_frw_e;
                mod_src_m = mod_src_e;
                mod_mr_m  = mod_mr_e;
                mod_mw_m  = mod_mw_e;
            end
        end
        if (ex_flush_e) begin
            clear_exec();
        end else if (!ex_stall_e) begin
            mod_rs1_e  = rs1_d;
            mod_rs2_e  = rs2_d;
            mod_rd_e   = rd_d;
            mod_fpu_e  = s_fpu_d;
            mod_rw_e   = reg_write_d;
            mod_frw_e  = fpu_reg_write_d;
            mod_src_e  = result_src_d;
            mod_mr_e   = mem_read_d;
            mod_mw_e   = mem_write_d;
            mod_disp_e = fpu_dispatch_d;
        end
    endtask

    // did this cycle show the hazard the test is aimed at
    function automatic logic target_hit(input int kind);
        case (kind)
            0: return (ex_fwd1 != pipe_pkg::fwd_int_none && ex_fwd1 != pipe_pkg::fwd_int_w);
            1: return (ex_ffwd1 == pipe_pkg::fwd_fpu_m_res
                       || ex_ffwd1 == pipe_pkg::fwd_fpu_m_rd1);
            2: return ex_lw && ex_flush_e;
            3: return ex_cache;
            4: return pc_src_e && ex_flush_e;
            default: return ex_stall_e && !ex_stall_mw;
        endcase
    endfunction

    task automatic run_test(input string name, input int kind);
        int errs_before;
        int checks_before;
        int hits;
        errs_before = errors;
        checks_before = checks;
        hits = 0;
        repeat (test_cycles) begin
            @(negedge clk);
            drive_inputs();
            #3;  // let the dut settle before the rising edge
            compute_expected();
            check_all();
            if (target_hit(kind))
                hits++;
            @(posedge clk);
            update_model();
        end
        if (hits == 0) begin
            errors++;
            $display("test %s: the targeted hazard never occurred", name);
        end
        $display("test %s: %0d checks, %0d errors", name, checks - checks_before,
                 errors - errs_before);
    endtask

    task automatic set_bias(input int load, input int fpu, input int mem, input int miss,
                            input int branch, input int io, input int disp, input int wait_pct);
        p_load   = load;
        p_fpu    = fpu;
        p_mem    = mem;
        p_miss   = miss;
        p_branch = branch;
        p_io     = io;
        p_disp   = disp;
        p_wait   = wait_pct;
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        seed = 32'h7e18;
        checks = 0;
        errors = 0;
        held = 1'b0;
        rs1_d = '0;
        rs2_d = '0;
        rd_d = '0;
        result_src_d = '0;
        s_fpu_d = 1'b0;
        reg_write_d = 1'b0;
        fpu_reg_write_d = 1'b0;
        mem_read_d = 1'b0;
        mem_write_d = 1'b0;
        fpu_dispatch_d = 1'b0;
        pc_src_e = 1'b0;
        cache_data_valid = 1'b1;
        in_stall = 1'b0;
        out_stall = 1'b0;
        fpu_valid = 1'b1;
        rf_rd1_e = '0;
        rf_rd2_e = '0;
        frf_rd1_e = '0;
        frf_rd2_e = '0;
        alu_result_m = '0;
        pc_plus4_m = '0;
        imm_ext_m = '0;
        fpu_rd1_m = '0;
        fpu_result_m = '0;
        rd1_m = '0;
        result_w = '0;
        clear_exec();
        clear_mem();
        mod_rd_w = '0;
        mod_rw_w = 1'b0;
        mod_frw_w = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;

        set_bias(5, 10, 10, 5, 5, 2, 5, 10);
        run_test("int_forward", 0);
        set_bias(5, 80, 10, 5, 5, 2, 5, 10);
        run_test("fpu_forward", 1);
        set_bias(50, 30, 10, 5, 5, 2, 5, 10);
        run_test("load_use", 2);
        set_bias(10, 30, 60, 60, 5, 2, 5, 10);
        run_test("cache_backpressure", 3);
        set_bias(10, 30, 20, 20, 40, 5, 20, 20);
        run_test("branch_flush", 4);
        set_bias(10, 30, 10, 5, 10, 20, 40, 50);
        run_test("io_fpu_wait", 5);

        $display("checks %0d, failed %0d", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // watchdog
    initial begin
        #(timeout);
        $display("timeout: the run did not finish within %0d time units", timeout);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: pipe_ctrl_top.f
hdl/pipe_pkg.sv
hdl/hazard_unit.sv
hdl/tag_pipeline.sv
hdl/operand_forward.sv
hdl/pipe_ctrl_top.sv
test/pipe_ctrl_tb.sv
